//--- prio_cfg_pkg.sv
/*
 * priority selector sizes and types
 */

package prio_cfg_pkg;

	// number of request lines
	localparam int REQ_WIDTH = 256;

	// fan-in of one select node
	localparam int GROUP_SIZE = 4;

	// one pipeline stage per tree level
	localparam int LEVELS = $clog2(REQ_WIDTH) / $clog2(GROUP_SIZE);

	// enough bits to name any request
	localparam int INDEX_WIDTH = $clog2(REQ_WIDTH);

	// request vector, also the carried grant
	typedef logic [REQ_WIDTH-1:0] req_vec_t;

	// binary position of the winner
	typedef logic [INDEX_WIDTH-1:0] index_t;

endpackage

//--- prio_util_pkg.sv
/*
 * priority selector helper functions
 */

package prio_util_pkg;

	import prio_cfg_pkg::*;

	// width of the any-vector entering a tree level
	// never below one bit, so small trees still fill all levels
	function automatic int any_width(input int level, input int req_width);
		int w;
		w = req_width;
		for (int l = 0; l < level; l++)
		begin
			if (w > GROUP_SIZE)
				w = w / GROUP_SIZE;
			else
				w = 1;
		end
		return w;
	endfunction

	// keep only the lowest set bit of every group of four
	function automatic req_vec_t group_first(input req_vec_t v);
		req_vec_t r;
		logic [GROUP_SIZE-1:0] grp;
		r = '0;
		for (int g = 0; g < REQ_WIDTH / GROUP_SIZE; g++)
		begin
			grp = v[g*GROUP_SIZE +: GROUP_SIZE];
			// two's complement isolates the lowest one
			r[g*GROUP_SIZE +: GROUP_SIZE] = grp & (~grp + 1'b1);
		end
		return r;
	endfunction

	// position of the set bit, zero when nothing is set
	function automatic index_t onehot_to_index(input req_vec_t v);
		index_t idx;
		idx = '0;
		for (int i = 0; i < REQ_WIDTH; i++)
		begin
			// or-encoder, exact only for one-hot input
			if (v[i])
				idx = idx | index_t'(i);
		end
		return idx;
	endfunction

endpackage

//--- grant_level.sv
/*
 * registered select tree level
 */

`timescale 1ns/100ps

module grant_level
	import prio_cfg_pkg::*;
	import prio_util_pkg::*;
#(
	parameter int REQ_WIDTH = prio_cfg_pkg::REQ_WIDTH,
	parameter int LEVEL = 0
)
(
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input logic [any_width(LEVEL, REQ_WIDTH)-1:0] in_any,
	input req_vec_t in_grant,
	output logic out_valid,
	output logic [any_width(LEVEL + 1, REQ_WIDTH)-1:0] out_any,
	output req_vec_t out_grant
);

	localparam int OUT_W = any_width(LEVEL + 1, REQ_WIDTH);

	// requests covered by one any bit at this level
	localparam int SPAN = GROUP_SIZE ** LEVEL;

	req_vec_t any_pad;
	req_vec_t win_pad;
	logic [OUT_W-1:0] any_next;
	req_vec_t grant_next;

	// zero extend so the shared select function fits every level
	assign any_pad = req_vec_t'(in_any);
	assign win_pad = group_first(any_pad);

	// one any bit per group of winners for the next level
	always_comb
	begin
		any_next = '0;
		for (int g = 0; g < OUT_W; g++)
		begin
			any_next[g] = |win_pad[g*GROUP_SIZE +: GROUP_SIZE];
		end
	end

	// a carried bit survives only if its span won here
	always_comb
	begin
		grant_next = '0;
		for (int i = 0; i < REQ_WIDTH; i++)
		begin
			grant_next[i] = in_grant[i] & win_pad[i / SPAN];
		end
	end

	// stage register
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			out_valid <= 1'b0;
			out_any <= '0;
			out_grant <= '0;
		end
		else
		begin
			out_valid <= in_valid;
			out_any <= any_next;
			out_grant <= grant_next;
		end
	end

endmodule

//--- grant_tree.sv
/*
 * pipelined select tree
 */

`timescale 1ns/100ps

module grant_tree
	import prio_cfg_pkg::*;
	import prio_util_pkg::*;
#(
	parameter int REQ_WIDTH = prio_cfg_pkg::REQ_WIDTH
)
(
	input logic clk,
	input logic arst_n,
	input logic req_valid,
	input req_vec_t req,
	output logic tree_valid,
	output req_vec_t tree_grant
);

	// entry l feeds level l, entry LEVELS is the tree result
	logic valid_chain [LEVELS+1];
	req_vec_t any_chain [LEVELS+1];
	req_vec_t grant_chain [LEVELS+1];

	// raw request is both the first any-vector and the first grant
	assign valid_chain[0] = req_valid;
	assign any_chain[0] = req;
	assign grant_chain[0] = req;

	for (genvar l = 0; l < LEVELS; l++)
	begin : g_level
		localparam int IN_W = any_width(l, REQ_WIDTH);
		localparam int OUT_W = any_width(l + 1, REQ_WIDTH);

		logic [OUT_W-1:0] any_out;

		grant_level #(
			.REQ_WIDTH(REQ_WIDTH),
			.LEVEL(l)
		) u_level (
			.clk(clk),
			.arst_n(arst_n),
			.in_valid(valid_chain[l]),
			.in_any(any_chain[l][IN_W-1:0]),
			.in_grant(grant_chain[l]),
			.out_valid(valid_chain[l + 1]),
			.out_any(any_out),
			.out_grant(grant_chain[l + 1])
		);

		assign any_chain[l + 1] = req_vec_t'(any_out);
	end

	// the last any bit only says something was requested
	assign tree_valid = valid_chain[LEVELS];
	assign tree_grant = grant_chain[LEVELS];

endmodule

//--- grant_output.sv
/*
 * grant output register
 */

`timescale 1ns/100ps

module grant_output
	import prio_cfg_pkg::*;
	import prio_util_pkg::*;
#(
	parameter int REQ_WIDTH = prio_cfg_pkg::REQ_WIDTH
)
(
	input logic clk,
	input logic arst_n,
	input logic tree_valid,
	input req_vec_t tree_grant,
	output logic grant_valid,
	output req_vec_t grant,
	output index_t grant_index,
	output logic grant_found
);

	// idle cycles load zeros so outputs are quiet without grant_valid
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			grant_valid <= 1'b0;
			grant <= '0;
			grant_index <= '0;
			grant_found <= 1'b0;
		end
		else if (tree_valid)
		begin
			grant_valid <= 1'b1;
			grant <= tree_grant;
			grant_index <= onehot_to_index(tree_grant);
			grant_found <= |tree_grant;
		end
		else
		begin
			grant_valid <= 1'b0;
			grant <= '0;
			grant_index <= '0;
			grant_found <= 1'b0;
		end
	end

endmodule

//--- prio_sel_top.sv
/*
 * pipelined priority selector
 */

`timescale 1ns/100ps

module prio_sel_top
	import prio_cfg_pkg::*;
#(
	parameter int REQ_WIDTH = prio_cfg_pkg::REQ_WIDTH
)
(
	input logic clk,
	input logic arst_n,
	input logic req_valid,
	input req_vec_t req,
	output logic grant_valid,
	output req_vec_t grant,
	output index_t grant_index,
	output logic grant_found
);

	logic tree_valid;
	req_vec_t tree_grant;

	// four tree stages
	grant_tree #(
		.REQ_WIDTH(REQ_WIDTH)
	) u_tree (
		.clk(clk),
		.arst_n(arst_n),
		.req_valid(req_valid),
		.req(req),
		.tree_valid(tree_valid),
		.tree_grant(tree_grant)
	);

	// fifth stage, index and found flag
	grant_output #(
		.REQ_WIDTH(REQ_WIDTH)
	) u_output (
		.clk(clk),
		.arst_n(arst_n),
		.tree_valid(tree_valid),
		.tree_grant(tree_grant),
		.grant_valid(grant_valid),
		.grant(grant),
		.grant_index(grant_index),
		.grant_found(grant_found)
	);

endmodule

//--- prio_sel_checker.sv
/*
 * priority selector result checker
 */

`timescale 1ns/100ps

module prio_sel_checker
	import prio_cfg_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic req_valid,
	input req_vec_t req,
	input logic grant_valid,
	input req_vec_t grant,
	input index_t grant_index,
	input logic grant_found
);

	localparam int LATENCY = 5;

	// expected results in arrival order
	req_vec_t exp_grant [$];
	index_t exp_index [$];
	logic exp_found [$];
	int exp_cycle [$];

	string test_name = "none";
	int cyc = 0;
	int errors = 0;
	int test_errors = 0;
	int test_results = 0;
	int tests_run = 0;
	int tests_failed = 0;

	// lowest set bit wins, found by a plain upward scan
	function automatic void ref_select(input req_vec_t v, output req_vec_t g,
		output index_t idx, output logic found);
		g = '0;
		idx = '0;
		found = 1'b0;
		for (int i = 0; i < REQ_WIDTH; i++)
		begin
			if (v[i] && !found)
			begin
				g[i] = 1'b1;
				idx = index_t'(i);
				found = 1'b1;
			end
		end
	endfunction

	function automatic int pending();
		return exp_grant.size();
	endfunction

	task automatic note_error(input string msg);
		$display("%s", msg);
		errors++;
		test_errors++;
	endtask

	task automatic drop_front();
		void'(exp_grant.pop_front());
		void'(exp_index.pop_front());
		void'(exp_found.pop_front());
		void'(exp_cycle.pop_front());
	endtask

	task automatic check_result();
		if (exp_grant.size() == 0)
			note_error($sformatf("a result arrived in %s with no vector pending", test_name));
		else
		begin
			test_results++;
			if (cyc - exp_cycle[0] != LATENCY)
				note_error($sformatf("result in %s came after %0d cycles instead of %0d",
					test_name, cyc - exp_cycle[0], LATENCY));
			if (grant !== exp_grant[0])
				note_error($sformatf("[FAIL] %s grant expected %h actual %h",
					test_name, exp_grant[0], grant));
			if (grant_index !== exp_index[0])
				note_error($sformatf("[FAIL] %s grant_index expected %0d actual %0d",
					test_name, exp_index[0], grant_index));
			if (grant_found !== exp_found[0])
				note_error($sformatf("[FAIL] %s grant_found expected %0b actual %0b",
					test_name, exp_found[0], grant_found));
			drop_front();
		end
	endtask

	task automatic check_idle();
		if (grant !== '0 || grant_index !== '0 || grant_found !== 1'b0)
			note_error($sformatf("outputs were not zero while grant_valid was low in %s",
				test_name));
		// a vector whose slot passed without a result
		if (exp_cycle.size() != 0 && cyc - exp_cycle[0] >= LATENCY)
		begin
			note_error($sformatf("an expected result never arrived in %s", test_name));
			drop_front();
		end
	endtask

	always @(posedge clk or negedge arst_n)
	begin
		req_vec_t g;
		index_t idx;
		logic found;
		if (!arst_n)
		begin
			// in-flight vectors are dropped by the reset
			exp_grant.delete();
			exp_index.delete();
			exp_found.delete();
			exp_cycle.delete();
		end
		else
		begin
			cyc++;
			if (grant_valid)
				check_result();
			else
				check_idle();
			if (req_valid)
			begin
				ref_select(req, g, idx, found);
				exp_grant.push_back(g);
				exp_index.push_back(idx);
				exp_found.push_back(found);
				exp_cycle.push_back(cyc);
			end
		end
	end

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
		test_results = 0;
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("test %-14s %0d results checked, %0d errors",
			test_name, test_results, test_errors);
	endtask

	task automatic final_report();
		if (exp_grant.size() != 0)
			note_error($sformatf("%0d expected results were still waiting at the end",
				exp_grant.size()));
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
	endtask

endmodule

//--- tb_prio_sel.sv
/*
 * priority selector testbench
 */

`timescale 1ns/100ps

module tb_prio_sel;

	import prio_cfg_pkg::*;

	localparam int SWEEP_VECS = REQ_WIDTH;
	localparam int EDGE_VECS = 2;
	localparam int LOWEST_VECS = 300;
	localparam int STREAM_VECS = 200;
	localparam int STREAM_GAP = 2;
	localparam int RESET_VECS = 10;
	localparam int NUM_TESTS = 5;

	// every vector, worst idle gaps, reset idle, latency per test, margin
	localparam int TIMEOUT = 2 + SWEEP_VECS + EDGE_VECS + LOWEST_VECS
		+ STREAM_VECS * (1 + STREAM_GAP) + RESET_VECS + 12
		+ NUM_TESTS * (5 + 2) + 100;

	logic clk = 1'b0;
	logic arst_n;
	logic req_valid;
	req_vec_t req;
	logic grant_valid;
	req_vec_t grant;
	index_t grant_index;
	logic grant_found;
	int cycles = 0;

	always #5 clk = ~clk;

	prio_sel_top #(
		.REQ_WIDTH(REQ_WIDTH)
	) dut (
		.clk(clk),
		.arst_n(arst_n),
		.req_valid(req_valid),
		.req(req),
		.grant_valid(grant_valid),
		.grant(grant),
		.grant_index(grant_index),
		.grant_found(grant_found)
	);

	prio_sel_checker chk (
		.clk(clk),
		.arst_n(arst_n),
		.req_valid(req_valid),
		.req(req),
		.grant_valid(grant_valid),
		.grant(grant),
		.grant_index(grant_index),
		.grant_found(grant_found)
	);

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT)
		begin
			$display("run timed out after %0d cycles", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic send_vec(input req_vec_t v);
		@(negedge clk);
		req_valid = 1'b1;
		req = v;
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		req_valid = 1'b0;
		req = '0;
	endtask

	// checker retires or flags every entry, so this ends
	task automatic drain();
		idle_cycle();
		while (chk.pending() != 0)
			@(negedge clk);
		@(negedge clk);
	endtask

	function automatic req_vec_t random_vec();
		req_vec_t v;
		for (int w = 0; w < REQ_WIDTH / 32; w++)
			v[w*32 +: 32] = $urandom();
		return v;
	endfunction

	// random bits above a randomly placed lowest one
	function automatic req_vec_t lowest_at_random();
		req_vec_t mask;
		int pos;
		pos = $urandom_range(0, REQ_WIDTH - 1);
		mask = '1;
		mask = mask << pos;
		return (random_vec() & mask) | (req_vec_t'(1) << pos);
	endfunction

	initial
	begin
		arst_n = 1'b0;
		req_valid = 1'b0;
		req = '0;
		void'($urandom(12750));
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		chk.begin_test("single_sweep");
		for (int i = 0; i < SWEEP_VECS; i++)
			send_vec(req_vec_t'(1) << i);
		drain();
		chk.end_test();

		chk.begin_test("empty_full");
		send_vec('0);
		send_vec('1);
		drain();
		chk.end_test();

		chk.begin_test("lowest_wins");
		for (int i = 0; i < LOWEST_VECS; i++)
			send_vec(lowest_at_random());
		drain();
		chk.end_test();

		chk.begin_test("stream_gaps");
		for (int i = 0; i < STREAM_VECS; i++)
		begin
			repeat ($urandom_range(0, STREAM_GAP)) idle_cycle();
			send_vec(random_vec());
		end
		drain();
		chk.end_test();

		chk.begin_test("reset_flight");
		for (int i = 0; i < RESET_VECS - 4; i++)
			send_vec(lowest_at_random());
		@(negedge clk);
		req_valid = 1'b0;
		req = '0;
		arst_n = 1'b0;
		@(negedge clk);
		arst_n = 1'b1;
		// any result now would belong to a dropped vector
		repeat (10) idle_cycle();
		for (int i = 0; i < 4; i++)
			send_vec(lowest_at_random());
		drain();
		chk.end_test();

		chk.final_report();
		if (chk.errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- vlog.f
prio_cfg_pkg.sv
prio_util_pkg.sv
grant_level.sv
grant_tree.sv
grant_output.sv
prio_sel_top.sv
prio_sel_checker.sv
tb_prio_sel.sv

//--- Makefile
TOOL := verilator
FLAGS := --binary --timing -Wno-fatal
TOP := tb_prio_sel
FILELIST := vlog.f

BUILD_DIR := obj_dir
SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(BUILD_DIR)
